//--- hdl/memArbiter.sv
`default_nettype none

module memArbiter (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire mpuPkg::fetchReqT fetchReq [2],
    input  wire mpuPkg::writeReqT writeReq [2],
    output logic [1:0]            fetchGrant,
    output logic [1:0]            writeGrant,
    input  wire logic             readDone,
    input  wire logic             writeDone,
    output logic                  startRead,
    output logic                  startWrite,
    output mpuPkg::vertexAddrT    readAddr,
    output mpuPkg::vertexAddrT    writeAddr,
    output mpuPkg::vertexT        writeData,
    output logic                  activeValid,
    output mpuPkg::vertexAddrT    activeAddr
);

    typedef enum logic [2:0] {
        PORT_IDLE,
        WRITE_A,
        WRITE_B,
        READ_A,
        READ_B
    } portStateT;

    portStateT state;
    logic      anyWrite;
    logic      anyRead;
    logic      wrLane;      // Winner, 0 is lane A
    logic      rdLane;

    // Fixed priority: writes before reads, A before B
    assign anyWrite = writeReq[0].req || writeReq[1].req;
    assign anyRead  = fetchReq[0].req || fetchReq[1].req;
    assign wrLane   = !writeReq[0].req;
    assign rdLane   = !fetchReq[0].req;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= PORT_IDLE;
            startRead   <= 1'b0;
            startWrite  <= 1'b0;
            activeValid <= 1'b0;
        end else begin
            startRead   <= 1'b0;
            startWrite  <= 1'b0;
            activeValid <= 1'b0;
            case (state)
                PORT_IDLE: begin
                    if (anyWrite) begin
                        state       <= wrLane ? WRITE_B : WRITE_A;
                        startWrite  <= 1'b1;
                        activeValid <= writeReq[wrLane].send;
                    end else if (anyRead) begin
                        state     <= rdLane ? READ_B : READ_A;
                        startRead <= 1'b1;
                    end
                end
                WRITE_A, WRITE_B: if (writeDone) state <= PORT_IDLE;
                READ_A, READ_B: if (readDone) state <= PORT_IDLE;
                default: state <= PORT_IDLE;
            endcase
        end
    end

    // Address and data frozen once the port is busy
    always_ff @(posedge clk) begin
        if (state == PORT_IDLE) begin
            readAddr  <= fetchReq[rdLane].addr;
            writeAddr <= writeReq[wrLane].addr;
            writeData <= writeReq[wrLane].data;
        end
    end

    assign activeAddr = writeAddr;      // Report rides on the granted write
    assign fetchGrant = {state == READ_B, state == READ_A};
    assign writeGrant = {state == WRITE_B, state == WRITE_A};

endmodule

`default_nettype wire

//--- hdl/messageUnit.sv
`default_nettype none

module messageUnit (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           msgEmpty,
    input  wire mpuPkg::msgT    msgData,
    output logic                msgRead,
    output mpuPkg::vertexAddrT  readAddr,
    output logic                startRead,
    input  wire logic           readDone,
    input  wire mpuPkg::vertexT readData,
    output mpuPkg::vertexAddrT  writeAddr,
    output mpuPkg::vertexT      writeData,
    output logic                startWrite,
    input  wire logic           writeDone,
    output logic                activeValid,
    output mpuPkg::vertexAddrT  activeAddr
);

    logic [1:0]                 laneIdle;
    logic [1:0]                 assignMsg;
    mpuPkg::msgT                laneMsg;
    logic [mpuPkg::INDEX_W-1:0] cacheAddr [2];
    logic [1:0]                 cacheWe;
    mpuPkg::cacheLineT          cacheWdata [2];
    mpuPkg::cacheLineT          cacheRdata [2];
    mpuPkg::fetchReqT           fetchReq [2];
    mpuPkg::writeReqT           writeReq [2];
    logic [1:0]                 fetchGrant;
    logic [1:0]                 writeGrant;

    msgDispatch u_dispatch (
        .clk, .reset, .msgEmpty, .msgData, .msgRead,
        .laneIdle, .assignMsg, .laneMsg
    );

    vertexCache u_cache (
        .clk, .reset,
        .addrA  (cacheAddr[0]),  .addrB  (cacheAddr[1]),
        .weA    (cacheWe[0]),    .weB    (cacheWe[1]),
        .wdataA (cacheWdata[0]), .wdataB (cacheWdata[1]),
        .rdataA (cacheRdata[0]), .rdataB (cacheRdata[1])
    );

    // Lane 0 is A, lane 1 is B
    for (genvar i = 0; i < 2; i++) begin : gLane
        vertexLane #(.LANE(i)) u_lane (
            .clk, .reset, .readDone, .readData, .writeDone,
            .assignMsg  (assignMsg[i]),  .laneMsg,
            .idle       (laneIdle[i]),   .cacheAddr  (cacheAddr[i]),
            .cacheWe    (cacheWe[i]),    .cacheWdata (cacheWdata[i]),
            .cacheRdata (cacheRdata[i]), .fetchReq   (fetchReq[i]),
            .fetchGrant (fetchGrant[i]), .writeReq   (writeReq[i]),
            .writeGrant (writeGrant[i])
        );
    end

    memArbiter u_arbiter (
        .clk, .reset, .fetchReq, .writeReq, .fetchGrant, .writeGrant,
        .readDone, .writeDone, .startRead, .startWrite,
        .readAddr, .writeAddr, .writeData, .activeValid, .activeAddr
    );

endmodule

`default_nettype wire

//--- hdl/mpuPkg.sv
`default_nettype none

package mpuPkg;

    // ========================================================================
    // Widths and sizes
    // ========================================================================
    localparam int INDEX_W     = 4;
    localparam int TAG_W       = 8;
    localparam int VADDR_W     = TAG_W + INDEX_W;   // 12 bit vertex address
    localparam int PROP_W      = 32;
    localparam int DEGREE_W    = 16;
    localparam int CACHE_DEPTH = 1 << INDEX_W;      // 16 lines

    // ========================================================================
    // Payload types
    // ========================================================================
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;      // Cache line select
    } vertexAddrT;

    typedef struct packed {
        vertexAddrT        addr;
        logic [PROP_W-1:0] value;       // Candidate for the min reduction
    } msgT;

    // Vertex record, same layout in the cache and in memory
    typedef struct packed {
        logic [PROP_W-1:0]   tempProp;
        logic [PROP_W-1:0]   prop;
        logic [DEGREE_W-1:0] degree;    // Outgoing edge count
        logic                active;
    } vertexT;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        vertexT           data;
    } cacheLineT;

    typedef struct packed {
        logic       req;
        vertexAddrT addr;
    } fetchReqT;

    typedef struct packed {
        logic       req;
        vertexAddrT addr;
        vertexT     data;
        logic       send;               // Vertex became active
    } writeReqT;

endpackage

`default_nettype wire

//--- hdl/msgDispatch.sv
`default_nettype none

module msgDispatch (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        msgEmpty,
    input  wire mpuPkg::msgT msgData,
    output logic             msgRead,
    input  wire logic [1:0]  laneIdle,
    output logic [1:0]       assignMsg,
    output mpuPkg::msgT      laneMsg
);

    logic                       loadPending;    // FIFO data valid this cycle
    logic                       held;
    mpuPkg::msgT                heldMsg;
    logic [mpuPkg::INDEX_W-1:0] laneIdx [2];    // Line each lane works on
    logic                       clashA;
    logic                       clashB;
    logic                       toA;
    logic                       toB;

    // A busy lane blocks its cache line for the other lane
    assign clashA = !laneIdle[0] && (laneIdx[0] == heldMsg.addr.index);
    assign clashB = !laneIdle[1] && (laneIdx[1] == heldMsg.addr.index);

    assign toA       = held && laneIdle[0] && !clashB;
    assign toB       = held && !toA && laneIdle[1] && !clashA;
    assign assignMsg = {toB, toA};
    assign laneMsg   = heldMsg;

    // ========================================================================
    // FIFO read and hold
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            msgRead     <= 1'b0;
            loadPending <= 1'b0;
            held        <= 1'b0;
        end else begin
            // One read in flight, only with a lane free to take it
            msgRead     <= !msgEmpty && !held && !msgRead && !loadPending && (|laneIdle);
            loadPending <= msgRead;
            if (loadPending) begin
                held <= 1'b1;
            end else if (toA || toB) begin
                held <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (loadPending) begin
            heldMsg <= msgData;
        end
        if (toA) begin
            laneIdx[0] <= heldMsg.addr.index;
        end
        if (toB) begin
            laneIdx[1] <= heldMsg.addr.index;
        end
    end

endmodule

`default_nettype wire

//--- hdl/vertexCache.sv
`default_nettype none

module vertexCache (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic [mpuPkg::INDEX_W-1:0] addrA,
    input  wire logic [mpuPkg::INDEX_W-1:0] addrB,
    input  wire logic                       weA,
    input  wire logic                       weB,
    input  wire mpuPkg::cacheLineT          wdataA,
    input  wire mpuPkg::cacheLineT          wdataB,
    output mpuPkg::cacheLineT               rdataA,
    output mpuPkg::cacheLineT               rdataB
);

    mpuPkg::cacheLineT              lines [mpuPkg::CACHE_DEPTH];
    logic [mpuPkg::CACHE_DEPTH-1:0] validBits;
    mpuPkg::cacheLineT              lineA;
    mpuPkg::cacheLineT              lineB;
    logic                           validA;
    logic                           validB;

    // Line storage, one synchronous port per lane
    always_ff @(posedge clk) begin
        if (weA) begin
            lines[addrA] <= wdataA;
        end
        if (weB) begin
            lines[addrB] <= wdataB;
        end
        lineA <= lines[addrA];
        lineB <= lines[addrB];
    end

    // Valid bits kept apart so reset can flush the whole cache
    always_ff @(posedge clk) begin
        if (reset) begin
            validBits <= '0;
            validA    <= 1'b0;
            validB    <= 1'b0;
        end else begin
            if (weA) begin
                validBits[addrA] <= wdataA.valid;
            end
            if (weB) begin
                validBits[addrB] <= wdataB.valid;
            end
            validA <= validBits[addrA];
            validB <= validBits[addrB];
        end
    end

    always_comb begin
        rdataA       = lineA;
        rdataA.valid = validA;
        rdataB       = lineB;
        rdataB.valid = validB;
    end

endmodule

`default_nettype wire

//--- hdl/vertexLane.sv
`default_nettype none

module vertexLane #(
    parameter int LANE = 0      // 0 is lane A, 1 is lane B
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       assignMsg,
    input  wire mpuPkg::msgT                laneMsg,
    output logic                            idle,
    output logic [mpuPkg::INDEX_W-1:0]      cacheAddr,
    output logic                            cacheWe,
    output mpuPkg::cacheLineT               cacheWdata,
    input  wire mpuPkg::cacheLineT          cacheRdata,
    output mpuPkg::fetchReqT                fetchReq,
    input  wire logic                       fetchGrant,
    input  wire logic                       readDone,
    input  wire mpuPkg::vertexT             readData,
    output mpuPkg::writeReqT                writeReq,
    input  wire logic                       writeGrant,
    input  wire logic                       writeDone
);

    typedef enum logic [2:0] {
        IDLE,
        CACHE_READ,
        HIT_MISS,
        FETCH,
        REDUCE,
        CACHE_WRITE,
        WRITE_BACK
    } laneStateT;

    laneStateT      state;
    mpuPkg::msgT    msgReg;
    mpuPkg::vertexT oldRec;     // From cache on hit, memory on miss
    mpuPkg::vertexT reduced;
    mpuPkg::vertexT newRec;
    logic           missed;
    logic           doUpdate;
    logic           doSend;
    logic           hit;
    logic           update;
    logic           send;

    assign hit = cacheRdata.valid && (cacheRdata.tag == msgReg.addr.tag);

    // ========================================================================
    // Min reduction
    // ========================================================================
    assign update = msgReg.value < oldRec.tempProp;
    assign send   = update && !oldRec.active && (oldRec.degree != '0);

    always_comb begin
        reduced = oldRec;       // Degree always kept
        if (update) begin
            reduced.tempProp = msgReg.value;
            reduced.prop     = msgReg.value;
            reduced.active   = oldRec.active || send;
        end
    end

    // ========================================================================
    // Lane FSM
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            cacheAddr <= LANE[mpuPkg::INDEX_W-1:0];   // Lanes start on different lines
        end else begin
            case (state)
                IDLE: begin
                    if (assignMsg) begin
                        cacheAddr <= laneMsg.addr.index;
                        state     <= CACHE_READ;
                    end
                end
                CACHE_READ: state <= HIT_MISS;     // Cache output registered
                HIT_MISS: state <= hit ? REDUCE : FETCH;
                FETCH: begin
                    if (fetchGrant && readDone) begin
                        state <= REDUCE;
                    end
                end
                // Fetched lines fill the cache even without an update
                REDUCE: state <= (update || missed) ? CACHE_WRITE : IDLE;
                CACHE_WRITE: state <= doUpdate ? WRITE_BACK : IDLE;
                WRITE_BACK: begin
                    if (writeGrant && writeDone) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && assignMsg) begin
            msgReg <= laneMsg;
        end
        if (state == HIT_MISS) begin
            missed <= !hit;
            if (hit) begin
                oldRec <= cacheRdata.data;
            end
        end
        if (state == FETCH && fetchGrant && readDone) begin
            oldRec <= readData;
        end
        if (state == REDUCE) begin
            newRec   <= reduced;
            doUpdate <= update;
            doSend   <= send;
        end
    end

    // Outputs
    assign idle       = (state == IDLE);
    assign cacheWe    = (state == CACHE_WRITE);
    assign cacheWdata = '{valid: 1'b1, tag: msgReg.addr.tag, data: newRec};
    assign fetchReq   = '{req: (state == FETCH), addr: msgReg.addr};
    assign writeReq   = '{req: (state == WRITE_BACK), addr: msgReg.addr,
                          data: newRec, send: doSend};   // Write-through of updates only

endmodule

`default_nettype wire

//--- messageUnit.f
hdl/mpuPkg.sv
hdl/msgDispatch.sv
hdl/vertexCache.sv
hdl/vertexLane.sv
hdl/memArbiter.sv
hdl/messageUnit.sv
tb/messageUnit_checker.sv
tb/messageUnitTb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module messageUnitTb -f messageUnit.f \
    && ./obj_dir/VmessageUnitTb | tee /dev/stderr | grep -q "TESTS PASSED" \
    || { echo "run.sh: simulation did not pass"; exit 1; }

//--- tb/messageUnitTb.sv
`default_nettype none

module messageUnitTb;

    localparam int NUM_MSG      = 20;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 20;
    localparam int QUIET_CYCLES = 40;
    localparam int NUM_VERTEX   = 1 << mpuPkg::VADDR_W;

    logic               clk;
    logic               reset;
    logic               msgEmpty;
    mpuPkg::msgT        msgData;
    logic               msgRead;
    mpuPkg::vertexAddrT readAddr;
    logic               startRead;
    logic               readDone;
    mpuPkg::vertexT     readData;
    mpuPkg::vertexAddrT writeAddr;
    mpuPkg::vertexT     writeData;
    logic               startWrite;
    logic               writeDone;
    logic               activeValid;
    mpuPkg::vertexAddrT activeAddr;

    // Columns are vertex address {tag, index} and candidate value
    mpuPkg::msgT msgTable [NUM_MSG] = '{
        {12'h013, 32'd500},     // Miss and first update with report
        {12'h013, 32'd400},     // Hit and smaller again without report
        {12'h013, 32'd450},     // Not smaller
        {12'h024, 32'd10},      // Degree 0 updates silently
        {12'h113, 32'd2000},    // Evicts 013 without update
        {12'h013, 32'd300},     // Read again and sees 400
        {12'h035, 32'd40},
        {12'h046, 32'd60},
        {12'h057, 32'd5000},
        {12'h068, 32'd7},
        {12'h079, 32'd99},
        {12'h08A, 32'd11},
        {12'h035, 32'd30},
        {12'h046, 32'd60},      // Equal is not smaller
        {12'h146, 32'd1},
        {12'h046, 32'd59},
        {12'h0FB, 32'd0},
        {12'h0FC, 32'd0},
        {12'h0FD, 32'd2000},
        {12'h0FD, 32'd1}
    };

    mpuPkg::vertexT   mem [NUM_VERTEX];
    mpuPkg::vertexT   refMem [NUM_VERTEX];
    int               readCount [NUM_VERTEX];
    int               expReads [NUM_VERTEX];
    mpuPkg::writeReqT expQ [$];             // Expected writes in message order
    int               expReadTotal;
    int               readsSeen;
    logic [15:0]      lfsr;
    int               ptr;

    messageUnit u_dut (
        .clk, .reset, .msgEmpty, .msgData, .msgRead, .readAddr, .startRead, .readDone,
        .readData, .writeAddr, .writeData, .startWrite, .writeDone, .activeValid, .activeAddr
    );

    // ========================================================================
    // Helpers
    // ========================================================================
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [127:0] got,
                              input logic [127:0] expected);
        if (got !== expected) begin
            abortRun($sformatf("CHECK FAILED at %0t: %s got %0h expected %0h",
                               $time, name, got, expected));
        end
    endtask

    function automatic mpuPkg::vertexT initialRecord(input int a);
        mpuPkg::vertexT r;
        r.tempProp = 32'(1000 + a);
        r.prop     = 32'(1000 + a);
        r.degree   = 16'(a % 4);
        r.active   = 1'b0;
        return r;
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drawDelay(output int d);
        logic [2:0] bits;
        bits = '0;
        for (int b = 0; b < 3; b++) begin
            lfsr = lfsrStep(lfsr);
            bits = {bits[1:0], lfsr[0]};
        end
        d = 2 + int'(bits);         // 2 to 9 cycles
    endtask

    // Reference model of cache tags and min reduction in message order
    task automatic buildExpected();
        logic                       cValid [mpuPkg::CACHE_DEPTH];
        logic [mpuPkg::TAG_W-1:0]   cTag [mpuPkg::CACHE_DEPTH];
        mpuPkg::vertexAddrT         vAddr;
        mpuPkg::vertexT             oldRec;
        mpuPkg::vertexT             newRec;
        mpuPkg::writeReqT           w;
        logic                       upd;
        logic                       snd;
        expReadTotal = 0;
        for (int i = 0; i < mpuPkg::CACHE_DEPTH; i++) begin
            cValid[i] = 1'b0;
            cTag[i]   = '0;
        end
        for (int a = 0; a < NUM_VERTEX; a++) begin
            refMem[a]   = initialRecord(a);
            expReads[a] = 0;
        end
        for (int m = 0; m < NUM_MSG; m++) begin
            vAddr = msgTable[m].addr;
            if (!cValid[vAddr.index] || cTag[vAddr.index] != vAddr.tag) begin
                expReads[vAddr] = expReads[vAddr] + 1;     // Miss fills the line
                expReadTotal    = expReadTotal + 1;
                cValid[vAddr.index] = 1'b1;
                cTag[vAddr.index]   = vAddr.tag;
            end
            oldRec = refMem[vAddr];
            upd    = msgTable[m].value < oldRec.tempProp;
            snd    = upd && !oldRec.active && (oldRec.degree != 16'd0);
            if (upd) begin
                newRec          = oldRec;
                newRec.tempProp = msgTable[m].value;
                newRec.prop     = msgTable[m].value;
                newRec.active   = oldRec.active || snd;
                refMem[vAddr]   = newRec;
                w.req  = 1'b1;
                w.addr = vAddr;
                w.data = newRec;
                w.send = snd;
                expQ.push_back(w);
            end
        end
    endtask

    // FIFO model with data valid the cycle after the read strobe
    task automatic feedFifo();
        if (msgRead) begin
            if (ptr >= NUM_MSG) begin
                abortRun("Message FIFO was read while empty");
            end else begin
                msgData  = msgTable[ptr];
                ptr      = ptr + 1;
                msgEmpty = (ptr >= NUM_MSG);
            end
        end
    endtask

    // ========================================================================
    // Clock, memory model, watchdog
    // ========================================================================
    initial begin : clockGen
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin : memoryModel
        int                 busyCnt;
        int                 pending;        // 0 none, 1 read, 2 write
        int                 hitIdx;
        mpuPkg::vertexAddrT pendAddr;
        mpuPkg::writeReqT   wantWrite;
        readDone    = 1'b0;
        writeDone   = 1'b0;
        readData    = '0;
        busyCnt     = 0;
        pending     = 0;
        pendAddr    = '0;
        readsSeen   = 0;
        lfsr        = 16'd50;
        for (int a = 0; a < NUM_VERTEX; a++) begin
            mem[a]       = initialRecord(a);
            readCount[a] = 0;
        end
        forever begin
            @(negedge clk);
            if (!reset && startRead && startWrite) begin
                abortRun("startRead and startWrite came in the same cycle");
            end else if (!reset && (startRead || startWrite) && pending != 0) begin
                abortRun("Memory start came before the previous transaction finished");
            end
            readDone  = 1'b0;
            writeDone = 1'b0;
            if (pending != 0) begin
                busyCnt = busyCnt - 1;
                if (busyCnt == 0) begin
                    if (pending == 1) begin
                        readData = mem[pendAddr];
                        readDone = 1'b1;
                    end else begin
                        writeDone = 1'b1;
                    end
                    pending = 0;
                end
            end
            if (!reset && startRead) begin
                readCount[readAddr] = readCount[readAddr] + 1;
                readsSeen = readsSeen + 1;
                pendAddr  = readAddr;
                pending   = 1;
                drawDelay(busyCnt);
            end
            if (!reset && startWrite) begin
                hitIdx = -1;
                for (int i = 0; i < expQ.size(); i++) begin
                    if (hitIdx < 0 && expQ[i].addr == writeAddr) begin
                        hitIdx = i;     // Oldest pending write for this vertex
                    end
                end
                if (hitIdx < 0) begin
                    abortRun($sformatf("Unexpected write to vertex %03h", writeAddr));
                end else begin
                    wantWrite = expQ[hitIdx];
                    expQ.delete(hitIdx);
                    checkValue("writeData", 128'(writeData), 128'(wantWrite.data));
                    checkValue("activeValid", 128'(activeValid), 128'(wantWrite.send));
                    if (activeValid) begin
                        checkValue("activeAddr", 128'(activeAddr), 128'(wantWrite.addr));
                    end
                    mem[writeAddr] = writeData;
                    pending        = 2;
                    drawDelay(busyCnt);
                end
            end
            if (!reset && activeValid && !startWrite) begin
                abortRun("Active report came without a write");
            end
        end
    end

    initial begin : watchdog
        repeat (NUM_MSG * 40 + RESET_CYCLES + IDLE_CYCLES + QUIET_CYCLES) @(posedge clk);
        abortRun("Watchdog timeout, the message table did not finish");
    end

    // ========================================================================
    // Stimulus
    // ========================================================================
    initial begin : stimulus
        reset    = 1'b1;
        msgEmpty = 1'b1;
        msgData  = '0;
        ptr      = 0;
        buildExpected();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // Unit must stay quiet while the FIFO is empty
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            checkValue("msgRead", 128'(msgRead), 128'(0));
            checkValue("startRead", 128'(startRead), 128'(0));
            checkValue("startWrite", 128'(startWrite), 128'(0));
            checkValue("activeValid", 128'(activeValid), 128'(0));
        end

        msgEmpty = 1'b0;
        while (ptr < NUM_MSG || expQ.size() != 0 || readsSeen < expReadTotal) begin
            @(negedge clk);
            feedFifo();
        end
        repeat (QUIET_CYCLES) begin     // Catch late extra traffic
            @(negedge clk);
            feedFifo();
        end

        for (int a = 0; a < NUM_VERTEX; a++) begin
            checkValue($sformatf("readCount[%03h]", a), 128'(readCount[a]),
                       128'(expReads[a]));
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/messageUnit_checker.sv
`default_nettype none

module messageUnitChecker (
    input wire logic clk,
    input wire logic reset,
    input wire logic startRead,
    input wire logic startWrite,
    input wire logic readDone,
    input wire logic writeDone,
    input wire logic activeValid
);

    logic busy;     // Transaction outstanding on the memory port

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (startRead || startWrite) begin
            busy <= 1'b1;
        end else if (readDone || writeDone) begin
            busy <= 1'b0;
        end
    end

    // ========================================================================
    // Memory port protocol
    // ========================================================================
    startsExclusive: assert property (@(posedge clk) disable iff (reset)
        !(startRead && startWrite))
        else $error("startRead and startWrite high in the same cycle");

    singleOutstanding: assert property (@(posedge clk) disable iff (reset)
        (startRead || startWrite) |-> !busy)
        else $error("New memory start before the previous done");

    reportWithWrite: assert property (@(posedge clk) disable iff (reset)
        activeValid |-> startWrite)
        else $error("activeValid without startWrite");

endmodule

bind memArbiter messageUnitChecker u_checker (
    .clk         (clk),
    .reset       (reset),
    .startRead   (startRead),
    .startWrite  (startWrite),
    .readDone    (readDone),
    .writeDone   (writeDone),
    .activeValid (activeValid)
);

`default_nettype wire
